// ==== list.f ====
src/aud_pkg.sv
src/aud_play_fsm.sv
src/aud_seq_counter.sv
src/aud_interp.sv
src/aud_dac_serializer.sv
src/aud_playback_top.sv
tb/tb_aud_playback.sv

// ==== tb/tb_aud_playback.sv ====
`timescale 1ns/1ns

module tb_aud_playback;

	// frames per run summed over all tests, two spare LR periods per run,
	// plus the pause and stop holds and some reset margin
	localparam int LR_PERIOD = 48;
	localparam int EXP_FRAMES = 130;
	localparam int RUNS = 11;
	localparam int EXTRA_PERIODS = 9;
	localparam int TIMEOUT_CYCLES = (EXP_FRAMES + 2 * RUNS + EXTRA_PERIODS) * LR_PERIOD;

	logic i_clk;
	logic i_rst_n;
	logic i_start;
	logic i_stop;
	logic i_pause;
	aud_pkg::play_mode_e i_mode;
	aud_pkg::speed_t i_speed;
	aud_pkg::addr_t i_rec_len;
	logic i_daclrck;
	aud_pkg::sample_t i_sram_data;
	aud_pkg::addr_t o_sram_addr;
	logic o_aud_dacdat;
	logic o_busy;
	logic o_finish;

	aud_pkg::sample_t mem [0:1023];
	aud_pkg::sample_t frames[$];
	aud_pkg::sample_t exp_q[$];
	logic [31:0] lfsr = 32'h6e74_7b65;
	int lr_cnt = 0;
	int cycles = 0;
	int err_count = 0;
	int check_count = 0;
	int test_count = 0;
	int test_err_start = 0;
	string test_name;
	aud_pkg::sample_t mon_shift = '0;
	logic [4:0] mon_left = '0;
	logic mon_lr_prev = 1'b0;

	aud_playback_top #(
		.ADDR_W(20),
		.MAX_SPEED(8)
	) dut (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_start(i_start),
		.i_stop(i_stop),
		.i_pause(i_pause),
		.i_mode(i_mode),
		.i_speed(i_speed),
		.i_rec_len(i_rec_len),
		.i_daclrck(i_daclrck),
		.i_sram_data(i_sram_data),
		.o_sram_addr(o_sram_addr),
		.o_aud_dacdat(o_aud_dacdat),
		.o_busy(o_busy),
		.o_finish(o_finish)
	);

	// asynchronous SRAM read
	assign i_sram_data = mem[o_sram_addr[9:0]];

	initial begin
		i_clk = 1'b0;
		forever #5 i_clk = ~i_clk;
	end

	// LR clock, 24 cycles high then 24 low
	always @(posedge i_clk) begin
		i_daclrck <= (lr_cnt < 24);
		lr_cnt <= (lr_cnt == LR_PERIOD - 1) ? 0 : lr_cnt + 1;
	end

	always @(posedge i_clk) begin
		cycles = cycles + 1;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("timeout: the run went past %0d cycles", TIMEOUT_CYCLES);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// decode 16 bits after each LR fall, sampled mid-cycle
	always @(negedge i_clk) begin
		if (mon_left != 0) begin
			mon_shift = {mon_shift[14:0], o_aud_dacdat};
			mon_left = mon_left - 5'd1;
			if (mon_left == 0 && mon_shift != 0)
				frames.push_back(mon_shift);
		end else if (mon_lr_prev && !i_daclrck) begin
			mon_left = 5'd16;
		end
		mon_lr_prev = i_daclrck;
	end

	function automatic logic next_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	task automatic fill_sram();
		aud_pkg::sample_t v;
		for (int a = 0; a < 1024; a++) begin
			for (int b = 0; b < 16; b++)
				v[b] = next_bit();
			// keeps every stored sample nonzero
			v[0] = 1'b1;
			mem[a] = v;
		end
	endtask

	// expected output sequence straight from the playback rules
	function automatic void build_expected(aud_pkg::play_mode_e mode, int n, int len);
		int a;
		int step;
		exp_q.delete();
		if (mode == aud_pkg::MODE_FAST) begin
			for (int k = 0; k * n <= len - 1; k++)
				exp_q.push_back(mem[k * n]);
		end else begin
			for (int j = 0; j < len - 1; j++) begin
				a = mem[j];
				step = (int'(mem[j + 1]) - a) / n;
				for (int k = 0; k < n; k++) begin
					if (mode == aud_pkg::MODE_SLOW_HOLD)
						exp_q.push_back(mem[j]);
					else
						exp_q.push_back(aud_pkg::sample_t'(a + k * step));
				end
			end
			exp_q.push_back(mem[len - 1]);
		end
	endfunction

	task automatic compare_sample(aud_pkg::sample_t got, aud_pkg::sample_t exp, string what);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("FAILED t=%0t: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic compare_count(aud_pkg::count_t got, aud_pkg::count_t exp, string what);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("FAILED t=%0t: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic compare_addr(aud_pkg::addr_t got, aud_pkg::addr_t exp, string what);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("FAILED t=%0t: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
		end
	endtask

	task automatic compare_bit(logic got, logic exp, string what);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("FAILED t=%0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic begin_test(string name);
		test_name = name;
		test_err_start = err_count;
		test_count++;
	endtask

	task automatic end_test();
		if (err_count == test_err_start)
			$display("test %-12s ok", test_name);
		else
			$display("test %-12s %0d errors", test_name, err_count - test_err_start);
	endtask

	task automatic wait_lr_fall();
		do
			@(posedge i_clk);
		while (lr_cnt != 24);
	endtask

	task automatic start_clip(aud_pkg::play_mode_e mode, int n, int len);
		build_expected(mode, n, len);
		wait_lr_fall();
		frames.delete();
		repeat (5) @(posedge i_clk);
		i_mode <= mode;
		i_speed <= aud_pkg::speed_t'(n);
		i_rec_len <= aud_pkg::addr_t'(len);
		i_start <= 1'b1;
		@(posedge i_clk);
		i_start <= 1'b0;
		@(posedge i_clk);
		compare_bit(o_busy, 1'b1, "o_busy after start");
	endtask

	task automatic wait_finish(int limit);
		int c;
		c = 0;
		while (!o_finish && c < limit) begin
			@(posedge i_clk);
			c++;
		end
		if (!o_finish) begin
			err_count++;
			$display("error: o_finish did not arrive within %0d cycles", limit);
		end else begin
			compare_bit(o_busy, 1'b0, "o_busy with o_finish");
		end
	endtask

	task automatic wait_frames(int n, int limit);
		int c;
		c = 0;
		while (frames.size() < n && c < limit) begin
			@(posedge i_clk);
			c++;
		end
		if (frames.size() < n) begin
			err_count++;
			$display("error: only %0d of %0d frames arrived", frames.size(), n);
		end
	endtask

	task automatic check_frames(int n);
		compare_count(aud_pkg::count_t'(frames.size()), aud_pkg::count_t'(n), "frame count");
		for (int i = 0; i < n && i < frames.size(); i++)
			compare_sample(frames[i], exp_q[i], $sformatf("frame %0d", i));
	endtask

	task automatic run_clip(aud_pkg::play_mode_e mode, int n, int len);
		start_clip(mode, n, len);
		wait_finish((exp_q.size() + 2) * LR_PERIOD);
		check_frames(exp_q.size());
	endtask

	task automatic test_reset_short();
		begin_test("reset_short");
		compare_bit(o_busy, 1'b0, "o_busy after reset");
		compare_bit(o_finish, 1'b0, "o_finish after reset");
		compare_bit(o_aud_dacdat, 1'b0, "o_aud_dacdat after reset");
		compare_addr(o_sram_addr, '0, "o_sram_addr after reset");
		run_clip(aud_pkg::MODE_FAST, 1, 2);
		run_clip(aud_pkg::MODE_SLOW_HOLD, 1, 2);
		run_clip(aud_pkg::MODE_SLOW_LINEAR, 1, 2);
		end_test();
	endtask

	task automatic test_fast();
		begin_test("fast");
		run_clip(aud_pkg::MODE_FAST, 1, 20);
		run_clip(aud_pkg::MODE_FAST, 3, 20);
		run_clip(aud_pkg::MODE_FAST, 8, 20);
		end_test();
	endtask

	task automatic test_hold();
		begin_test("slow_hold");
		run_clip(aud_pkg::MODE_SLOW_HOLD, 2, 6);
		run_clip(aud_pkg::MODE_SLOW_HOLD, 5, 6);
		end_test();
	endtask

	task automatic test_linear();
		begin_test("slow_linear");
		// rising, falling, flat and full-swing pairs
		mem[0] = 16'sd100;
		mem[1] = -16'sd7;
		mem[2] = 16'sd2001;
		mem[3] = 16'sd1999;
		mem[4] = -16'sd30000;
		mem[5] = 16'sd32001;
		run_clip(aud_pkg::MODE_SLOW_LINEAR, 4, 6);
		end_test();
	endtask

	task automatic test_pause();
		aud_pkg::addr_t hold_addr;
		aud_pkg::addr_t seen_addr;
		int held;
		begin_test("pause");
		start_clip(aud_pkg::MODE_SLOW_LINEAR, 3, 6);
		wait_frames(5, 7 * LR_PERIOD);
		repeat (3) @(posedge i_clk);
		i_pause <= 1'b1;
		@(posedge i_clk);
		hold_addr = o_sram_addr;
		seen_addr = hold_addr;
		held = frames.size();
		repeat (3 * LR_PERIOD) begin
			@(posedge i_clk);
			if (o_sram_addr !== hold_addr && seen_addr === hold_addr)
				seen_addr = o_sram_addr;
		end
		compare_addr(seen_addr, hold_addr, "o_sram_addr during pause");
		compare_count(aud_pkg::count_t'(frames.size()), aud_pkg::count_t'(held),
			"frames during pause");
		i_pause <= 1'b0;
		wait_finish((exp_q.size() + 6) * LR_PERIOD);
		check_frames(exp_q.size());
		end_test();
	endtask

	task automatic test_stop();
		begin_test("stop");
		start_clip(aud_pkg::MODE_FAST, 1, 20);
		wait_frames(4, 6 * LR_PERIOD);
		repeat (3) @(posedge i_clk);
		i_stop <= 1'b1;
		@(posedge i_clk);
		i_stop <= 1'b0;
		compare_bit(o_finish, 1'b0, "o_finish in the stop cycle");
		@(posedge i_clk);
		compare_bit(o_finish, 1'b1, "o_finish after stop");
		compare_bit(o_busy, 1'b0, "o_busy after stop");
		compare_addr(o_sram_addr, '0, "o_sram_addr after stop");
		repeat (3 * LR_PERIOD) @(posedge i_clk);
		check_frames(4);
		end_test();
	endtask

	initial begin
		i_rst_n = 1'b0;
		i_start = 1'b0;
		i_stop = 1'b0;
		i_pause = 1'b0;
		i_mode = aud_pkg::MODE_FAST;
		i_speed = aud_pkg::speed_t'(1);
		i_rec_len = aud_pkg::addr_t'(2);
		i_daclrck = 1'b0;
		fill_sram();
		repeat (3) @(posedge i_clk);
		i_rst_n <= 1'b1;
		@(posedge i_clk);
		test_reset_short();
		test_fast();
		test_hold();
		test_linear();
		test_pause();
		test_stop();
		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
		if (err_count == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== src/aud_playback_top.sv ====
`timescale 1ns/1ns

module aud_playback_top #(
	parameter int ADDR_W = 20,
	parameter int MAX_SPEED = 8
) (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_start,
	input  logic i_stop,
	input  logic i_pause,
	input  aud_pkg::play_mode_e i_mode,
	input  aud_pkg::speed_t i_speed,
	input  aud_pkg::addr_t i_rec_len,
	input  logic i_daclrck,
	input  aud_pkg::sample_t i_sram_data,
	output aud_pkg::addr_t o_sram_addr,
	output logic o_aud_dacdat,
	output logic o_busy,
	output logic o_finish
);

	logic cnt_clear;
	logic cnt_fetch_a;
	logic cnt_fetch_b;
	logic cnt_presented;
	logic ld_a;
	logic ld_b;
	logic present;
	logic ser_en;
	logic phase_zero;
	logic last_sample;
	logic frame_done;
	aud_pkg::sample_t out_sample;

	aud_play_fsm #(
		.MAX_SPEED(MAX_SPEED)
	) u_fsm (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_start(i_start),
		.i_stop(i_stop),
		.i_pause(i_pause),
		.i_mode(i_mode),
		.i_speed(i_speed),
		.i_frame_done(frame_done),
		.i_last_sample(last_sample),
		.o_cnt_clear(cnt_clear),
		.o_cnt_fetch_a(cnt_fetch_a),
		.o_cnt_fetch_b(cnt_fetch_b),
		.o_cnt_presented(cnt_presented),
		.o_ld_a(ld_a),
		.o_ld_b(ld_b),
		.o_present(present),
		.o_ser_en(ser_en),
		.o_busy(o_busy),
		.o_finish(o_finish)
	);

	aud_seq_counter #(
		.ADDR_W(ADDR_W),
		.MAX_SPEED(MAX_SPEED)
	) u_counter (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_start(i_start),
		.i_mode(i_mode),
		.i_speed(i_speed),
		.i_rec_len(i_rec_len),
		.i_clear(cnt_clear),
		.i_fetch_a(cnt_fetch_a),
		.i_fetch_b(cnt_fetch_b),
		.i_presented(cnt_presented),
		.o_sram_addr(o_sram_addr),
		.o_phase_zero(phase_zero),
		.o_last_sample(last_sample)
	);

	aud_interp u_interp (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_mode(i_mode),
		.i_speed(i_speed),
		.i_sram_data(i_sram_data),
		.i_ld_a(ld_a),
		.i_ld_b(ld_b),
		.i_present(present),
		.i_phase_zero(phase_zero),
		.o_sample(out_sample)
	);

	aud_dac_serializer u_serializer (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_en(ser_en),
		.i_daclrck(i_daclrck),
		.i_sample(out_sample),
		.o_dacdat(o_aud_dacdat),
		.o_frame_done(frame_done)
	);

endmodule

// ==== src/aud_dac_serializer.sv ====
`timescale 1ns/1ns

module aud_dac_serializer (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_en,
	input  logic i_daclrck,
	input  aud_pkg::sample_t i_sample,
	output logic o_dacdat,
	output logic o_frame_done
);

	localparam int CNT_W = $clog2(aud_pkg::SAMPLE_W);

	aud_pkg::sample_t shift_r;
	logic [CNT_W-1:0] bit_cnt;
	logic lrck_d;
	logic full_r;
	logic shifting_r;
	logic done_r;
	logic lrck_fall;
	logic capture;

	assign lrck_fall = lrck_d && !i_daclrck;
	// pick up a sample only in the left-high half
	assign capture = i_en && i_daclrck && !full_r && !shifting_r && !done_r;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			lrck_d <= 1'b0;
			full_r <= 1'b0;
			shifting_r <= 1'b0;
			done_r <= 1'b0;
			bit_cnt <= '0;
		end else begin
			lrck_d <= i_daclrck;
			done_r <= 1'b0;
			if (shifting_r) begin
				bit_cnt <= bit_cnt + CNT_W'(1);
				if (bit_cnt == CNT_W'(aud_pkg::SAMPLE_W - 1)) begin
					shifting_r <= 1'b0;
					done_r <= 1'b1;
				end
			end else if (!i_en) begin
				// dropped on pause or stop before the frame began
				full_r <= 1'b0;
			end else if (lrck_fall && full_r) begin
				shifting_r <= 1'b1;
				full_r <= 1'b0;
				bit_cnt <= '0;
			end else if (capture) begin
				full_r <= 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (capture)
			shift_r <= i_sample;
		else if (shifting_r)
			shift_r <= {shift_r[aud_pkg::SAMPLE_W-2:0], 1'b0};
	end

	assign o_dacdat = shifting_r && shift_r[aud_pkg::SAMPLE_W-1];
	assign o_frame_done = done_r;

	a_frame_len: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$rose(shifting_r) |-> (shifting_r && !done_r) [*16] ##1 (done_r && !shifting_r));

endmodule

// ==== src/aud_interp.sv ====
`timescale 1ns/1ns

module aud_interp (
	input  logic i_clk,
	input  logic i_rst_n,
	input  aud_pkg::play_mode_e i_mode,
	input  aud_pkg::speed_t i_speed,
	input  aud_pkg::sample_t i_sram_data,
	input  logic i_ld_a,
	input  logic i_ld_b,
	input  logic i_present,
	input  logic i_phase_zero,
	output aud_pkg::sample_t o_sample
);

	aud_pkg::sample_t a_r;
	aud_pkg::sample_t b_r;
	aud_pkg::sample_t out_r;
	logic signed [aud_pkg::SAMPLE_W:0] diff;
	logic signed [aud_pkg::SAMPLE_W:0] step;
	logic signed [aud_pkg::SPEED_BITS:0] div_n;
	logic linear_step;

	// one extra bit so B-A cannot overflow
	assign diff = {b_r[aud_pkg::SAMPLE_W-1], b_r} - {a_r[aud_pkg::SAMPLE_W-1], a_r};
	assign div_n = (i_speed == '0) ? (aud_pkg::SPEED_BITS+1)'(1) : $signed({1'b0, i_speed});
	// signed divide truncates toward zero
	assign step = diff / div_n;

	assign linear_step = (i_mode == aud_pkg::MODE_SLOW_LINEAR) && !i_phase_zero;

	always_ff @(posedge i_clk) begin
		if (i_ld_a)
			a_r <= i_sram_data;
		if (i_ld_b)
			b_r <= i_sram_data;
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			out_r <= '0;
		end else if (i_present) begin
			if (linear_step)
				out_r <= out_r + aud_pkg::sample_t'(step);
			else
				out_r <= a_r;
		end
	end

	assign o_sample = out_r;

endmodule

// ==== src/aud_seq_counter.sv ====
`timescale 1ns/1ns

module aud_seq_counter #(
	parameter int ADDR_W = 20,
	parameter int MAX_SPEED = 8
) (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_start,
	input  aud_pkg::play_mode_e i_mode,
	input  aud_pkg::speed_t i_speed,
	input  aud_pkg::addr_t i_rec_len,
	input  logic i_clear,
	input  logic i_fetch_a,
	input  logic i_fetch_b,
	input  logic i_presented,
	output aud_pkg::addr_t o_sram_addr,
	output logic o_phase_zero,
	output logic o_last_sample
);

	localparam int PH_W = (MAX_SPEED > 1) ? $clog2(MAX_SPEED) : 1;

	aud_pkg::play_mode_e mode_r;
	aud_pkg::speed_t n_r;
	aud_pkg::speed_t n_div;
	logic [ADDR_W-1:0] len_r;
	logic [ADDR_W-1:0] len_m1;
	logic [ADDR_W-1:0] addr_r;
	logic [ADDR_W-1:0] addr_next;
	logic [PH_W-1:0] phase_r;
	logic [PH_W-1:0] last_phase;
	aud_pkg::count_t sent_r;
	aud_pkg::count_t total;
	logic active_r;
	logic stepped_r;
	logic slow;
	logic wrap;
	logic step_ok;

	assign slow = (mode_r != aud_pkg::MODE_FAST);
	assign last_phase = PH_W'(n_r - aud_pkg::speed_t'(1));
	assign wrap = (phase_r == last_phase);
	assign n_div = (n_r == '0) ? aud_pkg::speed_t'(1) : n_r;
	assign len_m1 = len_r - ADDR_W'(1);

	// fast jumps N words, slow moves on to the B sample
	assign addr_next = addr_r + (slow ? ADDR_W'(1) : ADDR_W'(n_r));
	// never walk past the end of the clip
	assign step_ok = (addr_next < len_r);

	assign total = slow ?
		(aud_pkg::count_t'(n_r) * aud_pkg::count_t'(len_m1) + aud_pkg::count_t'(1)) :
		(aud_pkg::count_t'(len_m1 / ADDR_W'(n_div)) + aud_pkg::count_t'(1));

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			active_r <= 1'b0;
			mode_r <= aud_pkg::MODE_FAST;
			n_r <= aud_pkg::speed_t'(1);
			len_r <= '0;
			addr_r <= '0;
			phase_r <= '0;
			sent_r <= '0;
			stepped_r <= 1'b0;
		end else if (i_clear) begin
			active_r <= 1'b0;
			addr_r <= '0;
			phase_r <= '0;
			sent_r <= '0;
			stepped_r <= 1'b0;
		end else if (i_start && !active_r) begin
			active_r <= 1'b1;
			mode_r <= i_mode;
			n_r <= i_speed;
			len_r <= ADDR_W'(i_rec_len);
			addr_r <= '0;
			phase_r <= '0;
			sent_r <= '0;
			stepped_r <= 1'b0;
		end else begin
			if (i_fetch_a) begin
				stepped_r <= step_ok;
				if (step_ok)
					addr_r <= addr_next;
			end
			// back to A for the next step of the same pair
			if (i_fetch_b && slow && stepped_r && !wrap)
				addr_r <= addr_r - ADDR_W'(1);
			if (i_presented) begin
				sent_r <= sent_r + aud_pkg::count_t'(1);
				if (slow)
					phase_r <= wrap ? '0 : phase_r + PH_W'(1);
			end
		end
	end

	assign o_sram_addr = aud_pkg::addr_t'(addr_r);
	assign o_phase_zero = (phase_r == '0);
	assign o_last_sample = active_r && (sent_r == total);

	a_addr_in_clip: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		active_r |-> (aud_pkg::addr_t'(addr_r) < i_rec_len));

endmodule

// ==== src/aud_play_fsm.sv ====
`timescale 1ns/1ns

module aud_play_fsm #(
	parameter int MAX_SPEED = 8
) (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_start,
	input  logic i_stop,
	input  logic i_pause,
	input  aud_pkg::play_mode_e i_mode,
	input  aud_pkg::speed_t i_speed,
	input  logic i_frame_done,
	input  logic i_last_sample,
	output logic o_cnt_clear,
	output logic o_cnt_fetch_a,
	output logic o_cnt_fetch_b,
	output logic o_cnt_presented,
	output logic o_ld_a,
	output logic o_ld_b,
	output logic o_present,
	output logic o_ser_en,
	output logic o_busy,
	output logic o_finish
);

	aud_pkg::play_state_e state_r;
	aud_pkg::play_state_e state_nx;
	aud_pkg::play_mode_e mode_r;
	logic finish_r;
	logic busy;
	logic slow;
	logic end_run;
	logic do_fetch_a;
	logic do_fetch_b;
	logic do_present;

	assign busy = (state_r != aud_pkg::ST_IDLE);
	assign slow = (mode_r != aud_pkg::MODE_FAST);

	// stop, or the final frame has just gone out
	assign end_run = busy && (i_stop || (state_r == aud_pkg::ST_SEND &&
		i_frame_done && i_last_sample));

	// fetch and present steps stall while paused
	assign do_fetch_a = (state_r == aud_pkg::ST_FETCH_A) && !i_pause;
	assign do_fetch_b = (state_r == aud_pkg::ST_FETCH_B) && !i_pause;
	assign do_present = (state_r == aud_pkg::ST_PRESENT) && !i_pause;

	always_comb begin
		state_nx = state_r;
		case (state_r)
			aud_pkg::ST_IDLE: begin
				if (i_start)
					state_nx = aud_pkg::ST_FETCH_A;
			end
			aud_pkg::ST_FETCH_A: begin
				if (i_pause)
					state_nx = aud_pkg::ST_PAUSED;
				else if (slow)
					state_nx = aud_pkg::ST_FETCH_B;
				else
					state_nx = aud_pkg::ST_PRESENT;
			end
			aud_pkg::ST_FETCH_B: begin
				if (!i_pause)
					state_nx = aud_pkg::ST_PRESENT;
			end
			aud_pkg::ST_PRESENT: begin
				if (!i_pause)
					state_nx = aud_pkg::ST_SEND;
			end
			aud_pkg::ST_SEND: begin
				if (i_frame_done) begin
					if (i_last_sample)
						state_nx = aud_pkg::ST_IDLE;
					else if (i_pause)
						state_nx = aud_pkg::ST_PAUSED;
					else
						state_nx = aud_pkg::ST_FETCH_A;
				end
			end
			aud_pkg::ST_PAUSED: begin
				if (!i_pause)
					state_nx = aud_pkg::ST_FETCH_A;
			end
			default: state_nx = aud_pkg::ST_IDLE;
		endcase
		if (busy && i_stop)
			state_nx = aud_pkg::ST_IDLE;
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state_r <= aud_pkg::ST_IDLE;
			mode_r <= aud_pkg::MODE_FAST;
			finish_r <= 1'b0;
		end else begin
			state_r <= state_nx;
			finish_r <= end_run;
			if (state_r == aud_pkg::ST_IDLE && i_start)
				mode_r <= i_mode;
		end
	end

	assign o_cnt_clear = end_run;
	assign o_cnt_fetch_a = do_fetch_a;
	assign o_ld_a = do_fetch_a;
	assign o_cnt_fetch_b = do_fetch_b;
	assign o_ld_b = do_fetch_b;
	assign o_cnt_presented = do_present;
	assign o_present = do_present;
	// serializer may only pick up the sample while not paused
	assign o_ser_en = (state_r == aud_pkg::ST_SEND) && !i_pause;
	assign o_busy = busy;
	assign o_finish = finish_r;

	a_speed_legal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(state_r == aud_pkg::ST_IDLE && i_start) |->
		(i_speed >= aud_pkg::speed_t'(1) && i_speed <= aud_pkg::speed_t'(MAX_SPEED)));

	a_finish_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_finish |=> !o_finish);

endmodule

// ==== src/aud_pkg.sv ====
package aud_pkg;

	// widths shared by the playback blocks
	localparam int SAMPLE_W = 16;
	localparam int ADDR_BITS = 20;
	localparam int SPEED_BITS = 4;
	localparam int COUNT_BITS = 24;

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic [ADDR_BITS-1:0] addr_t;
	typedef logic [SPEED_BITS-1:0] speed_t;
	typedef logic [COUNT_BITS-1:0] count_t;

	typedef enum logic [1:0] {
		MODE_FAST = 2'd0,
		MODE_SLOW_HOLD = 2'd1,
		MODE_SLOW_LINEAR = 2'd2
	} play_mode_e;

	// one output sample is fetch, present, then send
	typedef enum logic [2:0] {
		ST_IDLE = 3'd0,
		ST_FETCH_A = 3'd1,
		ST_FETCH_B = 3'd2,
		ST_PRESENT = 3'd3,
		ST_SEND = 3'd4,
		ST_PAUSED = 3'd5
	} play_state_e;

endpackage
